// File: bicubic_pkg.sv
package bicubic_pkg;

    localparam int IMG_W   = 100;  // source image width in pixels
    localparam int COORD_W = 7;    // coordinate or size
    localparam int FRAC_W  = 8;    // Q0.8 fraction
    localparam int PIX_W   = 8;
    localparam int ROM_AW  = 14;

    // one scaling job, window origin plus source and target sizes
    typedef struct packed {
        logic [COORD_W-1:0] h0;
        logic [COORD_W-1:0] v0;
        logic [COORD_W-1:0] sw;
        logic [COORD_W-1:0] sh;
        logic [COORD_W-1:0] tw;
        logic [COORD_W-1:0] th;
    } job_t;

    // one result memory write
    typedef struct packed {
        logic                 en;
        logic [2*COORD_W-1:0] addr;  // {ty, tx}
        logic [PIX_W-1:0]     data;
    } wr_t;

    typedef enum logic [1:0] {
        IDLE,
        TABLE,   // fraction tables being filled
        RUN,
        FINISH   // ack high, waiting for req to drop
    } ctrl_state_e;

    // where the engine takes its taps from
    typedef enum logic {
        PASS_H,  // image ROM
        PASS_V   // column buffer
    } pass_e;

endpackage

// File: frac_divider.sv
`timescale 1ns/1ps

module frac_divider import bicubic_pkg::*; (
    input  logic               CLK,
    input  logic               RST,
    input  logic               start_i,
    input  logic [COORD_W-1:0] dividend_i,
    input  logic [COORD_W-1:0] divisor_i,
    output logic               done_o,
    output logic [FRAC_W-1:0]  quot_o
);

    logic               busy;
    logic [2:0]         step;     // quotient bit in progress
    logic [COORD_W-1:0] rem;      // always below the divisor
    logic [COORD_W-1:0] dvsr;
    logic [COORD_W:0]   rem_dbl;
    logic [COORD_W:0]   diff;

    assign rem_dbl = {rem, 1'b0};
    assign diff    = rem_dbl - {1'b0, dvsr};

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy   <= 1'b0;
            step   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == 3'd7) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;  // ninth cycle after start
                end
            end
        end
    end

    // restoring step, one bit per cycle
    always_ff @(posedge CLK) begin
        if (start_i) begin
            rem    <= dividend_i;
            dvsr   <= divisor_i;
            quot_o <= '0;
        end else if (busy) begin
            if (rem_dbl >= {1'b0, dvsr}) begin
                rem    <= diff[COORD_W-1:0];
                quot_o <= {quot_o[FRAC_W-2:0], 1'b1};
            end else begin
                rem    <= rem_dbl[COORD_W-1:0];
                quot_o <= {quot_o[FRAC_W-2:0], 1'b0};
            end
        end
    end

endmodule

// File: frac_table.sv
`timescale 1ns/1ps

module frac_table import bicubic_pkg::*; #(
    parameter int MAX_T = 32
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               we_i,
    input  logic               sel_i,      // 1 selects the vertical table
    input  logic [COORD_W-1:0] idx_i,
    input  logic [FRAC_W-1:0]  wdata_i,
    input  logic [COORD_W-1:0] rem_h_i,
    input  logic [COORD_W-1:0] rem_v_i,
    output logic [FRAC_W-1:0]  frac_h_o,
    output logic [FRAC_W-1:0]  frac_v_o
);

    localparam int DEPTH = MAX_T - 1;     // one entry per remainder value
    localparam int IW    = $clog2(DEPTH);

    logic [FRAC_W-1:0] tbl_h [DEPTH];
    logic [FRAC_W-1:0] tbl_v [DEPTH];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < DEPTH; i++) begin
                tbl_h[i] <= '0;
                tbl_v[i] <= '0;
            end
        end else if (we_i) begin
            if (sel_i) tbl_v[idx_i[IW-1:0]] <= wdata_i;
            else       tbl_h[idx_i[IW-1:0]] <= wdata_i;
        end
    end

    assign frac_h_o = tbl_h[rem_h_i[IW-1:0]];
    assign frac_v_o = tbl_v[rem_v_i[IW-1:0]];

endmodule

// File: rom_addr_gen.sv
`timescale 1ns/1ps

module rom_addr_gen import bicubic_pkg::*; #(
    parameter int IMG_W = bicubic_pkg::IMG_W
) (
    input  logic [COORD_W-1:0] h0_i,
    input  logic [COORD_W-1:0] v0_i,
    input  logic [COORD_W-1:0] quot_h_i,
    input  logic [COORD_W-1:0] quot_v_i,
    input  logic [1:0]         tap_i,     // 0..3 for columns -1..2
    input  logic [1:0]         dy_i,      // 0..3 for rows -1..2
    output logic [ROM_AW-1:0]  addr_o
);

    localparam logic signed [COORD_W+1:0] ONE = 1;

    logic signed [COORD_W+1:0] row;
    logic signed [COORD_W+1:0] col;

    assign row = $signed({2'b00, v0_i}) + $signed({2'b00, quot_v_i})
               + $signed({{COORD_W{1'b0}}, dy_i}) - ONE;
    assign col = $signed({2'b00, h0_i}) + $signed({2'b00, quot_h_i})
               + $signed({{COORD_W{1'b0}}, tap_i}) - ONE;

    // row major, window rules keep both terms non-negative
    assign addr_o = ROM_AW'(row) * ROM_AW'(IMG_W) + ROM_AW'(col);

endmodule

// File: cubic_engine.sv
`timescale 1ns/1ps

module cubic_engine import bicubic_pkg::*; (
    input  logic              CLK,
    input  logic              RST,
    input  pass_e             pass_i,
    input  logic [FRAC_W-1:0] x_i,
    input  logic              tap_valid_i,
    input  logic [PIX_W-1:0]  rom_data_i,
    input  logic [1:0]        dy_i,
    output logic              result_valid_o,
    output logic [PIX_W-1:0]  result_o
);

    localparam int ACC_W = 24;

    logic [FRAC_W-1:0]       x2, x3;
    logic [2*FRAC_W-1:0]     sq_raw, cu_raw;
    logic [1:0]              tcnt;                   // taps taken so far
    logic [PIX_W-1:0]        p0, p1, p2;
    logic [PIX_W-1:0]        p3;                     // live tap
    logic [PIX_W-1:0]        col_buf [4];            // H results, one per row offset
    logic signed [ACC_W-1:0] s0, s1, s2, s3;
    logic signed [ACC_W-1:0] sx, sx2, sx3;
    logic signed [ACC_W-1:0] a1, a2, a3, base;
    logic signed [ACC_W-1:0] acc, rnd;
    logic [PIX_W-1:0]        pix;

    // power chain with rounding
    assign sq_raw = x_i * x_i + 16'd128;
    assign cu_raw = x2 * x_i + 16'd128;

    assign p3 = (pass_i == PASS_V) ? col_buf[tcnt] : rom_data_i;

    assign s0  = ACC_W'(p0);
    assign s1  = ACC_W'(p1);
    assign s2  = ACC_W'(p2);
    assign s3  = ACC_W'(p3);
    assign sx  = ACC_W'(x_i);
    assign sx2 = ACC_W'(x2);
    assign sx3 = ACC_W'(x3);

    // Catmull-Rom coefficients, scaled by 2
    assign a1   = s2 - s0;
    assign a2   = (s0 <<< 1) - ((s1 <<< 2) + s1) + (s2 <<< 2) - s3;
    assign a3   = (s1 <<< 1) + s1 - (s2 <<< 1) - s2 + s3 - s0;
    assign base = s1 <<< 9;

    assign acc = base + a1 * sx + a2 * sx2 + a3 * sx3 + ACC_W'(256);
    assign rnd = acc >>> 9;

    always_comb begin
        if (rnd[ACC_W-1]) begin
            pix = '0;                     // undershoot
        end else if (rnd[ACC_W-2:PIX_W] != '0) begin
            pix = '1;                     // overshoot
        end else begin
            pix = rnd[PIX_W-1:0];
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            tcnt           <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= tap_valid_i && (tcnt == 2'd3);
            if (tap_valid_i) tcnt <= tcnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        x2 <= sq_raw[2*FRAC_W-1:FRAC_W];
        x3 <= cu_raw[2*FRAC_W-1:FRAC_W];
        if (tap_valid_i) begin
            p0 <= p1;
            p1 <= p2;
            p2 <= p3;
            if (tcnt == 2'd3) begin
                result_o <= pix;
                if (pass_i == PASS_H) col_buf[dy_i] <= pix;  // row result for the V pass
            end
        end
    end

endmodule

// File: bicubic_ctrl.sv
`timescale 1ns/1ps

module bicubic_ctrl import bicubic_pkg::*; #(
    parameter int MAX_T = 32
) (
    input  logic               CLK,
    input  logic               RST,
    input  logic               req_i,
    input  job_t               job_i,
    input  logic               div_done_i,
    input  logic               result_valid_i,
    input  logic [PIX_W-1:0]   result_i,
    output logic               ack_o,
    output logic               div_start_o,
    output logic [COORD_W-1:0] dividend_o,
    output logic [COORD_W-1:0] divisor_o,
    output logic               tbl_we_o,
    output logic               tbl_sel_o,
    output logic [COORD_W-1:0] tbl_idx_o,
    output logic [COORD_W-1:0] rem_h_o,
    output logic [COORD_W-1:0] rem_v_o,
    output logic [COORD_W-1:0] quot_h_o,
    output logic [COORD_W-1:0] quot_v_o,
    output logic [1:0]         tap_o,
    output logic [1:0]         dy_o,
    output pass_e              pass_o,
    output logic               tap_valid_o,
    output logic               rom_rd_o,
    output wr_t                wr_o
);

    localparam int CNT_W = $clog2(MAX_T);

    ctrl_state_e        state;
    logic [COORD_W-1:0] sw_m1, sh_m1, tw_m1, th_m1;  // sizes minus one
    logic               div_go;
    logic               tbl_sel;                     // 1 = vertical table
    logic [COORD_W-1:0] tbl_idx;
    logic [2:0]         cyc;                         // cycle within a pass
    logic [2:0]         pcnt;                        // 0..3 H, 4 V, 5 write
    logic [CNT_W-1:0]   tx, ty;
    logic [COORD_W-1:0] rem_h, rem_v, quot_h, quot_v;
    logic [COORD_W-1:0] sum_h, sum_v;
    logic               run;

    // next source position before the wrap test
    assign sum_h = rem_h + sw_m1;
    assign sum_v = rem_v + sh_m1;
    assign run   = (state == RUN);

    // job sizes, taken once per job
    always_ff @(posedge CLK) begin
        if (state == IDLE && req_i) begin
            sw_m1 <= job_i.sw - 1'b1;
            sh_m1 <= job_i.sh - 1'b1;
            tw_m1 <= job_i.tw - 1'b1;
            th_m1 <= job_i.th - 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state   <= IDLE;
            div_go  <= 1'b0;
            tbl_sel <= 1'b0;
            tbl_idx <= '0;
            cyc     <= '0;
            pcnt    <= '0;
            tx      <= '0;
            ty      <= '0;
            rem_h   <= '0;
            rem_v   <= '0;
            quot_h  <= '0;
            quot_v  <= '0;
        end else begin
            div_go <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (req_i) begin
                        tbl_sel <= 1'b0;
                        tbl_idx <= '0;
                        div_go  <= 1'b1;  // first horizontal entry
                        state   <= TABLE;
                    end
                end
                TABLE: begin
                    if (div_done_i) begin
                        if (tbl_sel && tbl_idx == th_m1 - 1'b1) begin
                            state  <= RUN;
                            cyc    <= '0;
                            pcnt   <= '0;
                            tx     <= '0;
                            ty     <= '0;
                            rem_h  <= '0;
                            rem_v  <= '0;
                            quot_h <= '0;
                            quot_v <= '0;
                        end else begin
                            div_go <= 1'b1;
                            if (!tbl_sel && tbl_idx == tw_m1 - 1'b1) begin
                                tbl_sel <= 1'b1;  // on to the vertical table
                                tbl_idx <= '0;
                            end else begin
                                tbl_idx <= tbl_idx + 1'b1;
                            end
                        end
                    end
                end
                RUN: begin
                    if (pcnt == 3'd5) begin
                        // write cycle, step to the next target pixel
                        pcnt <= '0;
                        cyc  <= '0;
                        if (COORD_W'(tx) == tw_m1) begin
                            tx     <= '0;
                            rem_h  <= '0;
                            quot_h <= '0;
                            if (COORD_W'(ty) == th_m1) begin
                                state <= FINISH;
                            end else begin
                                ty <= ty + 1'b1;
                                if (sum_v >= th_m1) begin
                                    rem_v  <= sum_v - th_m1;
                                    quot_v <= quot_v + 1'b1;
                                end else begin
                                    rem_v <= sum_v;
                                end
                            end
                        end else begin
                            tx <= tx + 1'b1;
                            if (sum_h >= tw_m1) begin
                                rem_h  <= sum_h - tw_m1;
                                quot_h <= quot_h + 1'b1;
                            end else begin
                                rem_h <= sum_h;
                            end
                        end
                    end else if (cyc == 3'd4) begin
                        cyc  <= '0;
                        pcnt <= pcnt + 1'b1;
                    end else begin
                        cyc <= cyc + 1'b1;
                    end
                end
                FINISH: begin
                    if (!req_i) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ack_o       = (state == FINISH);
    assign div_start_o = div_go;
    assign dividend_o  = tbl_idx;                   // remainder value of this entry
    assign divisor_o   = tbl_sel ? th_m1 : tw_m1;
    assign tbl_we_o    = (state == TABLE) && div_done_i;
    assign tbl_sel_o   = tbl_sel;
    assign tbl_idx_o   = tbl_idx;

    assign rem_h_o  = rem_h;
    assign rem_v_o  = rem_v;
    assign quot_h_o = quot_h;
    assign quot_v_o = quot_v;

    assign pass_o      = (pcnt == 3'd4) ? PASS_V : PASS_H;
    assign dy_o        = pcnt[1:0];
    assign tap_o       = cyc[1:0];
    assign rom_rd_o    = run && (pcnt < 3'd4) && (cyc < 3'd4);
    assign tap_valid_o = run && (pcnt < 3'd5) && (cyc != 3'd0);  // ROM data lags a cycle

    always_comb begin
        wr_o.en   = run && (pcnt == 3'd5) && result_valid_i;
        wr_o.addr = {COORD_W'(ty), COORD_W'(tx)};
        wr_o.data = result_i;
    end

endmodule

// File: bicubic_scaler.sv
`timescale 1ns/1ps

module bicubic_scaler import bicubic_pkg::*; #(
    parameter int IMG_W = bicubic_pkg::IMG_W,
    parameter int MAX_T = 32
) (
    input  logic              CLK,
    input  logic              RST,
    input  logic              req_i,
    input  job_t              job_i,
    output logic              ack_o,
    output logic              rom_rd_o,
    output logic [ROM_AW-1:0] rom_addr_o,
    input  logic [PIX_W-1:0]  rom_data_i,
    output wr_t               wr_o
);

    logic               div_start, div_done;
    logic [COORD_W-1:0] dividend, divisor;
    logic [FRAC_W-1:0]  div_quot;
    logic               tbl_we, tbl_sel;
    logic [COORD_W-1:0] tbl_idx;
    logic [COORD_W-1:0] rem_h, rem_v, quot_h, quot_v;
    logic [FRAC_W-1:0]  frac_h, frac_v, x_cur;
    logic [1:0]         tap, dy;
    pass_e              pass;
    logic               tap_valid, result_valid;
    logic [PIX_W-1:0]   result;

    assign x_cur = (pass == PASS_V) ? frac_v : frac_h;

    bicubic_ctrl #(.MAX_T(MAX_T)) u_ctrl (
        .CLK, .RST, .req_i, .job_i,
        .div_done_i(div_done), .result_valid_i(result_valid), .result_i(result),
        .ack_o, .div_start_o(div_start), .dividend_o(dividend), .divisor_o(divisor),
        .tbl_we_o(tbl_we), .tbl_sel_o(tbl_sel), .tbl_idx_o(tbl_idx),
        .rem_h_o(rem_h), .rem_v_o(rem_v), .quot_h_o(quot_h), .quot_v_o(quot_v),
        .tap_o(tap), .dy_o(dy), .pass_o(pass), .tap_valid_o(tap_valid),
        .rom_rd_o, .wr_o
    );

    frac_divider u_div (
        .CLK, .RST, .start_i(div_start), .dividend_i(dividend), .divisor_i(divisor),
        .done_o(div_done), .quot_o(div_quot)
    );

    frac_table #(.MAX_T(MAX_T)) u_tbl (
        .CLK, .RST, .we_i(tbl_we), .sel_i(tbl_sel), .idx_i(tbl_idx), .wdata_i(div_quot),
        .rem_h_i(rem_h), .rem_v_i(rem_v), .frac_h_o(frac_h), .frac_v_o(frac_v)
    );

    // job_i stays stable while req_i is high
    rom_addr_gen #(.IMG_W(IMG_W)) u_addr (
        .h0_i(job_i.h0), .v0_i(job_i.v0), .quot_h_i(quot_h), .quot_v_i(quot_v),
        .tap_i(tap), .dy_i(dy), .addr_o(rom_addr_o)
    );

    cubic_engine u_eng (
        .CLK, .RST, .pass_i(pass), .x_i(x_cur), .tap_valid_i(tap_valid),
        .rom_data_i, .dy_i(dy), .result_valid_o(result_valid), .result_o(result)
    );

endmodule

// File: tb_bicubic.sv
`timescale 1ns/1ps

module tb_bicubic import bicubic_pkg::*; ();

    localparam int NUM_JOBS   = 7;
    localparam int MAX_T      = 32;
    localparam int MAX_CYCLES = NUM_JOBS * (64 * 10 + 32 * 32 * 26 + 100);
    localparam int SEED       = 34498;

    logic              CLK;
    logic              RST;
    logic              req;
    job_t              job;
    logic              ack;
    logic              rom_rd;
    logic [ROM_AW-1:0] rom_addr;
    logic [PIX_W-1:0]  rom_data = '0;
    wr_t               wr;

    logic [PIX_W-1:0] rom_img [IMG_W*IMG_W];    // source image
    logic [PIX_W-1:0] res_mem [1<<ROM_AW];      // result memory, {ty, tx}
    int               wr_tag  [1<<ROM_AW];      // job number of the last write
    job_t             cur;                      // job under test
    logic             req_q = 1'b0;
    int               job_no = 0;
    int               n_wr = 0;                 // writes seen in this job
    int               cycles = 0;
    int               checks = 0, errors = 0;
    int               mon_checks = 0, mon_errors = 0;

    bicubic_scaler #(.IMG_W(IMG_W), .MAX_T(MAX_T)) i_dut (
        .CLK, .RST, .req_i(req), .job_i(job), .ack_o(ack), .rom_rd_o(rom_rd),
        .rom_addr_o(rom_addr), .rom_data_i(rom_data), .wr_o(wr)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // image ROM, one cycle read latency
    always @(posedge CLK) begin
        if (rom_rd) rom_data <= rom_img[rom_addr];
    end

    // watch ROM reads and capture result writes
    always @(posedge CLK) begin
        int row, col, tx, ty;
        if (req && !req_q) begin
            job_no = job_no + 1;  // new job seen
            n_wr   = 0;
        end
        req_q = req;
        mon_checks++;
        assert (RST || req || (!rom_rd && !wr.en)) else begin
            mon_errors++;
            $display("CHECK FAILED at %0t: ROM read or write without a request", $time);
        end
        if (rom_rd) begin
            row = int'(rom_addr) / IMG_W;
            col = int'(rom_addr) % IMG_W;
            mon_checks++;
            assert (row >= int'(cur.v0) - 1 && row <= int'(cur.v0) + int'(cur.sh) + 1 &&
                    col >= int'(cur.h0) - 1 && col <= int'(cur.h0) + int'(cur.sw) + 1)
            else begin
                mon_errors++;
                $display("CHECK FAILED at %0t: ROM read at row %0d col %0d outside the window",
                         $time, row, col);
            end
        end
        if (wr.en) begin
            ty = int'(wr.addr[2*COORD_W-1:COORD_W]);
            tx = int'(wr.addr[COORD_W-1:0]);
            mon_checks++;
            assert (tx < int'(cur.tw) && ty < int'(cur.th) && wr_tag[wr.addr] != job_no)
            else begin
                mon_errors++;
                $display("CHECK FAILED at %0t: bad or repeated write at ty %0d tx %0d",
                         $time, ty, tx);
            end
            res_mem[wr.addr] = wr.data;
            wr_tag[wr.addr]  = job_no;
            n_wr             = n_wr + 1;
        end
    end

    // run limit
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("checks %0d, errors %0d", checks + mon_checks, errors + mon_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_that(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, what);
        end
    endtask

    // Catmull-Rom with the shared rounding, taps p0..p3, Q0.8 x
    function automatic int catmull_rom(input int p0, input int p1, input int p2,
                                       input int p3, input int x);
        int x2, x3, a1, a2, a3, s;
        x2 = (x * x + 128) >> 8;
        x3 = (x2 * x + 128) >> 8;
        a1 = p2 - p0;
        a2 = 2 * p0 - 5 * p1 + 4 * p2 - p3;
        a3 = 3 * p1 - 3 * p2 + p3 - p0;
        s  = (512 * p1 + a1 * x + a2 * x2 + a3 * x3 + 256) >>> 9;
        if (s < 0) return 0;
        if (s > 255) return 255;
        return s;
    endfunction

    function automatic int model_pixel(input job_t j, input int tx, input int ty);
        int sw1, sh1, tw1, th1;
        int qh, rh, qv, rv, fh, fv;
        int base;
        int col [4];
        sw1 = int'(j.sw) - 1;
        sh1 = int'(j.sh) - 1;
        tw1 = int'(j.tw) - 1;
        th1 = int'(j.th) - 1;
        qh  = tx * sw1 / tw1;
        rh  = tx * sw1 % tw1;
        qv  = ty * sh1 / th1;
        rv  = ty * sh1 % th1;
        fh  = rh * 256 / tw1;  // Q0.8 fractions
        fv  = rv * 256 / th1;
        for (int dy = 0; dy < 4; dy++) begin
            base = (int'(j.v0) + qv + dy - 1) * IMG_W + int'(j.h0) + qh - 1;
            col[dy] = catmull_rom(int'(rom_img[ROM_AW'(base)]),
                                  int'(rom_img[ROM_AW'(base + 1)]),
                                  int'(rom_img[ROM_AW'(base + 2)]),
                                  int'(rom_img[ROM_AW'(base + 3)]), fh);
        end
        return catmull_rom(col[0], col[1], col[2], col[3], fv);
    endfunction

    // legal upscaling job, optionally at scale one
    function automatic job_t random_job(input bit identity);
        job_t j;
        int sw, sh, tw, th;
        sw = 2 + int'($urandom % 31);
        sh = 2 + int'($urandom % 31);
        tw = identity ? sw : sw + int'($urandom % (33 - sw));
        th = identity ? sh : sh + int'($urandom % (33 - sh));
        j.sw = COORD_W'(sw);
        j.sh = COORD_W'(sh);
        j.tw = COORD_W'(tw);
        j.th = COORD_W'(th);
        j.h0 = COORD_W'(1 + int'($urandom % (98 - sw)));  // taps stay inside
        j.v0 = COORD_W'(1 + int'($urandom % (98 - sh)));
        return j;
    endfunction

    task automatic run_job(input job_t j);
        int hold;
        cur = j;
        job <= j;
        req <= 1'b1;
        do @(posedge CLK); while (!ack);
        check_that(n_wr == int'(j.tw) * int'(j.th),
                   $sformatf("ack after %0d of %0d writes", n_wr, int'(j.tw) * int'(j.th)));
        repeat (3) begin
            @(posedge CLK);
            check_that(ack, "ack fell while req was high");
        end
        req <= 1'b0;
        hold = 0;
        do begin
            @(posedge CLK);
            hold++;
        end while (ack && hold < 3);
        check_that(!ack, "ack still high after req fell");
    endtask

    task automatic compare_results(input job_t j);
        int a, exp_pix, src;
        for (int ty = 0; ty < int'(j.th); ty++) begin
            for (int tx = 0; tx < int'(j.tw); tx++) begin
                a = (ty << COORD_W) + tx;
                check_that(wr_tag[ROM_AW'(a)] == job_no,
                           $sformatf("pixel ty %0d tx %0d never written", ty, tx));
                exp_pix = model_pixel(j, tx, ty);
                check_that(int'(res_mem[ROM_AW'(a)]) == exp_pix,
                           $sformatf("pixel ty %0d tx %0d is %0d, expected %0d",
                                     ty, tx, res_mem[ROM_AW'(a)], exp_pix));
                if (j.sw == j.tw && j.sh == j.th) begin
                    src = int'(rom_img[ROM_AW'((int'(j.v0) + ty) * IMG_W + int'(j.h0) + tx)]);
                    check_that(int'(res_mem[ROM_AW'(a)]) == src,
                               $sformatf("identity pixel ty %0d tx %0d differs from source",
                                         ty, tx));
                end
            end
        end
    endtask

    initial begin
        job_t jobs [NUM_JOBS];
        RST = 1'b1;
        req = 1'b0;
        job = '0;
        cur = '0;
        void'($urandom(SEED));
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            rom_img[ROM_AW'(i)] = PIX_W'($urandom);
        end
        for (int i = 0; i < NUM_JOBS - 1; i++) begin
            jobs[i] = random_job(i == 2);  // job 2 at scale one
        end
        jobs[NUM_JOBS-1] = '{h0: 7'd40, v0: 7'd50, sw: 7'd17, sh: 7'd15, tw: 7'd22, th: 7'd28};

        repeat (4) @(posedge CLK);
        RST <= 1'b0;
        repeat (6) begin
            @(posedge CLK);
            check_that(!ack && !rom_rd && !wr.en, "DUT active before the first request");
        end

        for (int i = 0; i < NUM_JOBS; i++) begin
            run_job(jobs[i]);
            compare_results(jobs[i]);
        end

        $display("checks %0d, errors %0d", checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
bicubic_pkg.sv
frac_divider.sv
frac_table.sv
rom_addr_gen.sv
cubic_engine.sv
bicubic_ctrl.sv
bicubic_scaler.sv
tb_bicubic.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_bicubic
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
